/* source/decodeStage.sv */
`default_nettype none
`timescale 1ns/100ps

module decodeStage #(
	parameter mipsIsaPkg::word_t RESET_PC = 32'hbfc0_0000
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic stallD,
	input wire logic flushD,
	input wire logic fetchValid,
	input wire pipelinePkg::fetchData_t fetch,
	input wire logic regWriteM,
	input wire mipsIsaPkg::regAddr_t writeRegM,
	input wire mipsIsaPkg::word_t aluOutM,
	regReadIntf.reader rf,
	pcSelectIntf.source pcSel,
	output logic execValid,
	output pipelinePkg::decodeData_t exec
);

	pipelinePkg::fetchData_t fetchD;
	pipelinePkg::decodeData_t dataD;
	pipelinePkg::decodeData_t bubble;
	pipelinePkg::decodeData_t idExIn;
	pipelinePkg::forward_t forwardA;
	pipelinePkg::forward_t forwardB;
	mipsIsaPkg::jIndex_t jIndex;
	logic validD;
	logic idExValidIn;
	logic srcNeg;
	logic srcZero;
	logic taken;

	decodeCtlIntf dec ();

	// IF/ID
	pipeReg #(
		.payload_t(pipelinePkg::fetchData_t)
	) ifIdReg (
		.clk(clk),
		.rstN(rstN),
		.stall(stallD),
		.flush(flushD),
		.validIn(fetchValid),
		.dataIn(fetch),
		.validOut(validD),
		.dataOut(fetchD)
	);

	assign dec.instr = fetchD.instr;

	instrDecoder decoder (
		.ctl(dec.decoder)
	);

	assign jIndex = fetchD.instr[25:0];

	// field split, control gated by the stage valid
	assign dataD.operation = dec.operation;
	assign dataD.ctl = validD ? dec.ctl : '0;
	assign dataD.rs = fetchD.instr[25:21];
	assign dataD.rt = fetchD.instr[20:16];
	assign dataD.rd = fetchD.instr[15:11];
	assign dataD.shamt = fetchD.instr[10:6];
	assign dataD.extImm = dec.extImm;
	assign dataD.pcPlus4 = fetchD.pcPlus4;
	assign dataD.exceptionRi = validD && dec.exceptionRi;

	assign rf.ra1 = dataD.rs;
	assign rf.ra2 = dataD.rt;

	// forward the MEM-stage result, never for $0
	assign forwardA = (regWriteM && writeRegM != '0 && writeRegM == dataD.rs) ?
		pipelinePkg::FWD_MEM : pipelinePkg::FWD_NONE;
	assign forwardB = (regWriteM && writeRegM != '0 && writeRegM == dataD.rt) ?
		pipelinePkg::FWD_MEM : pipelinePkg::FWD_NONE;
	assign dataD.srcA = (forwardA == pipelinePkg::FWD_MEM) ? aluOutM : rf.rd1;
	assign dataD.srcB = (forwardB == pipelinePkg::FWD_MEM) ? aluOutM : rf.rd2;

	assign srcNeg = dataD.srcA[31];
	assign srcZero = (dataD.srcA == '0);

	always_comb begin
		case (dataD.operation)
			mipsIsaPkg::BEQ: taken = (dataD.srcA == dataD.srcB);
			mipsIsaPkg::BNE: taken = (dataD.srcA != dataD.srcB);
			mipsIsaPkg::BGEZ, mipsIsaPkg::BGEZAL: taken = !srcNeg;
			mipsIsaPkg::BLTZ, mipsIsaPkg::BLTZAL: taken = srcNeg;
			mipsIsaPkg::BGTZ: taken = !srcNeg && !srcZero;
			mipsIsaPkg::BLEZ: taken = srcNeg || srcZero;
			default: taken = 1'b0;
		endcase
	end

	assign pcSel.pcBranch = fetchD.pcPlus4 + {dataD.extImm[29:0], 2'b00};
	assign pcSel.pcJump = {fetchD.pcPlus4[31:28], jIndex, 2'b00};
	assign pcSel.pcJr = dataD.srcA;
	assign pcSel.branchTaken = dataD.ctl.branch && taken;
	assign pcSel.jump = dataD.ctl.jump;
	assign pcSel.jr = dataD.ctl.jr;

	// a stall or empty slot sends a bubble to execute
	always_comb begin
		bubble = '0;
		bubble.pcPlus4 = RESET_PC;
	end

	assign idExValidIn = validD && !stallD;
	assign idExIn = idExValidIn ? dataD : bubble;

	// ID/EX
	pipeReg #(
		.payload_t(pipelinePkg::decodeData_t)
	) idExReg (
		.clk(clk),
		.rstN(rstN),
		.stall(1'b0),
		.flush(1'b0),
		.validIn(idExValidIn),
		.dataIn(idExIn),
		.validOut(execValid),
		.dataOut(exec)
	);

endmodule

`default_nettype wire

/* source/decodeTop.sv */
`default_nettype none
`timescale 1ns/100ps

module decodeTop #(
	parameter mipsIsaPkg::word_t RESET_PC = 32'hbfc0_0000
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic stallD,
	input wire logic flushD,
	input wire logic fetchValid,
	input wire mipsIsaPkg::word_t instr,
	input wire mipsIsaPkg::word_t pcPlus4,
	input wire logic regWriteM,
	input wire mipsIsaPkg::regAddr_t writeRegM,
	input wire mipsIsaPkg::word_t aluOutM,
	input wire logic wbWrite,
	input wire mipsIsaPkg::regAddr_t wbReg,
	input wire mipsIsaPkg::word_t wbData,
	output mipsIsaPkg::word_t pcBranch,
	output mipsIsaPkg::word_t pcJump,
	output mipsIsaPkg::word_t pcJr,
	output logic branchTaken,
	output logic jump,
	output logic jr,
	output logic execValid,
	output mipsIsaPkg::operation_t execOperation,
	output pipelinePkg::ctl_t execCtl,
	output mipsIsaPkg::regAddr_t execRs,
	output mipsIsaPkg::regAddr_t execRt,
	output mipsIsaPkg::regAddr_t execRd,
	output mipsIsaPkg::regAddr_t execShamt,
	output mipsIsaPkg::word_t execExtImm,
	output mipsIsaPkg::word_t execSrcA,
	output mipsIsaPkg::word_t execSrcB,
	output mipsIsaPkg::word_t execPcPlus4,
	output logic execExceptionRi
);

	pipelinePkg::fetchData_t fetch;
	pipelinePkg::decodeData_t exec;

	regReadIntf rfRead ();
	pcSelectIntf pcSel ();

	assign fetch.instr = instr;
	assign fetch.pcPlus4 = pcPlus4;

	decodeStage #(
		.RESET_PC(RESET_PC)
	) stage (
		.clk(clk),
		.rstN(rstN),
		.stallD(stallD),
		.flushD(flushD),
		.fetchValid(fetchValid),
		.fetch(fetch),
		.regWriteM(regWriteM),
		.writeRegM(writeRegM),
		.aluOutM(aluOutM),
		.rf(rfRead.reader),
		.pcSel(pcSel.source),
		.execValid(execValid),
		.exec(exec)
	);

	regFile regs (
		.clk(clk),
		.rstN(rstN),
		.wbWrite(wbWrite),
		.wbReg(wbReg),
		.wbData(wbData),
		.rd(rfRead.file)
	);

	// next-pc selection goes to fetch
	assign pcBranch = pcSel.pcBranch;
	assign pcJump = pcSel.pcJump;
	assign pcJr = pcSel.pcJr;
	assign branchTaken = pcSel.branchTaken;
	assign jump = pcSel.jump;
	assign jr = pcSel.jr;

	// ID/EX word split for execute
	assign execOperation = exec.operation;
	assign execCtl = exec.ctl;
	assign execRs = exec.rs;
	assign execRt = exec.rt;
	assign execRd = exec.rd;
	assign execShamt = exec.shamt;
	assign execExtImm = exec.extImm;
	assign execSrcA = exec.srcA;
	assign execSrcB = exec.srcB;
	assign execPcPlus4 = exec.pcPlus4;
	assign execExceptionRi = exec.exceptionRi;

endmodule

`default_nettype wire

/* source/instrDecoder.sv */
`default_nettype none
`timescale 1ns/100ps

module instrDecoder (
	decodeCtlIntf.decoder ctl
);

	mipsIsaPkg::op_t op;
	mipsIsaPkg::func_t func;
	mipsIsaPkg::regAddr_t rtField;
	mipsIsaPkg::imm_t imm;
	mipsIsaPkg::operation_t operation;
	pipelinePkg::ctl_t bundle;
	logic rType;
	logic zeroExt;

	assign op = ctl.instr[31:26];
	assign func = ctl.instr[5:0];
	assign rtField = ctl.instr[20:16];
	assign imm = ctl.instr[15:0];
	assign rType = (op == mipsIsaPkg::OP_RTYPE);

	always_comb begin
		operation = mipsIsaPkg::RESERVED;
		case (op)
			mipsIsaPkg::OP_RTYPE: begin
				case (func)
					mipsIsaPkg::F_SLL: operation = mipsIsaPkg::SLL;
					mipsIsaPkg::F_SRL: operation = mipsIsaPkg::SRL;
					mipsIsaPkg::F_SRA: operation = mipsIsaPkg::SRA;
					mipsIsaPkg::F_SLLV: operation = mipsIsaPkg::SLLV;
					mipsIsaPkg::F_SRLV: operation = mipsIsaPkg::SRLV;
					mipsIsaPkg::F_SRAV: operation = mipsIsaPkg::SRAV;
					mipsIsaPkg::F_JR: operation = mipsIsaPkg::JR;
					mipsIsaPkg::F_JALR: operation = mipsIsaPkg::JALR;
					mipsIsaPkg::F_MFHI: operation = mipsIsaPkg::MFHI;
					mipsIsaPkg::F_MFLO: operation = mipsIsaPkg::MFLO;
					mipsIsaPkg::F_ADD: operation = mipsIsaPkg::ADD;
					mipsIsaPkg::F_ADDU: operation = mipsIsaPkg::ADDU;
					mipsIsaPkg::F_SUB: operation = mipsIsaPkg::SUB;
					mipsIsaPkg::F_SUBU: operation = mipsIsaPkg::SUBU;
					mipsIsaPkg::F_AND: operation = mipsIsaPkg::AND;
					mipsIsaPkg::F_OR: operation = mipsIsaPkg::OR;
					mipsIsaPkg::F_XOR: operation = mipsIsaPkg::XOR;
					mipsIsaPkg::F_NOR: operation = mipsIsaPkg::NOR;
					mipsIsaPkg::F_SLT: operation = mipsIsaPkg::SLT;
					mipsIsaPkg::F_SLTU: operation = mipsIsaPkg::SLTU;
					default: operation = mipsIsaPkg::RESERVED;
				endcase
			end
			// branch kind sits in rt
			mipsIsaPkg::OP_REGIMM: begin
				case (rtField)
					mipsIsaPkg::RT_BLTZ: operation = mipsIsaPkg::BLTZ;
					mipsIsaPkg::RT_BGEZ: operation = mipsIsaPkg::BGEZ;
					mipsIsaPkg::RT_BLTZAL: operation = mipsIsaPkg::BLTZAL;
					mipsIsaPkg::RT_BGEZAL: operation = mipsIsaPkg::BGEZAL;
					default: operation = mipsIsaPkg::RESERVED;
				endcase
			end
			mipsIsaPkg::OP_J: operation = mipsIsaPkg::J;
			mipsIsaPkg::OP_JAL: operation = mipsIsaPkg::JAL;
			mipsIsaPkg::OP_BEQ: operation = mipsIsaPkg::BEQ;
			mipsIsaPkg::OP_BNE: operation = mipsIsaPkg::BNE;
			mipsIsaPkg::OP_BLEZ: operation = mipsIsaPkg::BLEZ;
			mipsIsaPkg::OP_BGTZ: operation = mipsIsaPkg::BGTZ;
			mipsIsaPkg::OP_ADDI: operation = mipsIsaPkg::ADDI;
			mipsIsaPkg::OP_ADDIU: operation = mipsIsaPkg::ADDIU;
			mipsIsaPkg::OP_SLTI: operation = mipsIsaPkg::SLTI;
			mipsIsaPkg::OP_SLTIU: operation = mipsIsaPkg::SLTIU;
			mipsIsaPkg::OP_ANDI: operation = mipsIsaPkg::ANDI;
			mipsIsaPkg::OP_ORI: operation = mipsIsaPkg::ORI;
			mipsIsaPkg::OP_XORI: operation = mipsIsaPkg::XORI;
			mipsIsaPkg::OP_LUI: operation = mipsIsaPkg::LUI;
			mipsIsaPkg::OP_LB: operation = mipsIsaPkg::LB;
			mipsIsaPkg::OP_LH: operation = mipsIsaPkg::LH;
			mipsIsaPkg::OP_LW: operation = mipsIsaPkg::LW;
			mipsIsaPkg::OP_LBU: operation = mipsIsaPkg::LBU;
			mipsIsaPkg::OP_LHU: operation = mipsIsaPkg::LHU;
			mipsIsaPkg::OP_SB: operation = mipsIsaPkg::SB;
			mipsIsaPkg::OP_SH: operation = mipsIsaPkg::SH;
			mipsIsaPkg::OP_SW: operation = mipsIsaPkg::SW;
			default: operation = mipsIsaPkg::RESERVED;
		endcase
	end

	always_comb begin
		// all but stores, plain branches and jumps write a register
		bundle.regWrite = !(operation inside {
			mipsIsaPkg::SB, mipsIsaPkg::SH, mipsIsaPkg::SW, mipsIsaPkg::J, mipsIsaPkg::JR,
			mipsIsaPkg::BEQ, mipsIsaPkg::BNE, mipsIsaPkg::BLEZ, mipsIsaPkg::BGTZ,
			mipsIsaPkg::BLTZ, mipsIsaPkg::BGEZ, mipsIsaPkg::RESERVED});
		bundle.memRead = operation inside {mipsIsaPkg::LB, mipsIsaPkg::LBU, mipsIsaPkg::LH,
			mipsIsaPkg::LHU, mipsIsaPkg::LW};
		bundle.memWrite = operation inside {mipsIsaPkg::SB, mipsIsaPkg::SH, mipsIsaPkg::SW};
		bundle.regDst = rType ? pipelinePkg::RD : pipelinePkg::RT;
		bundle.aluSrc = rType ? pipelinePkg::REG : pipelinePkg::IMM;
		bundle.branch = operation inside {mipsIsaPkg::BEQ, mipsIsaPkg::BNE, mipsIsaPkg::BLEZ,
			mipsIsaPkg::BGTZ, mipsIsaPkg::BLTZ, mipsIsaPkg::BGEZ, mipsIsaPkg::BLTZAL,
			mipsIsaPkg::BGEZAL};
		bundle.jump = operation inside {mipsIsaPkg::J, mipsIsaPkg::JAL, mipsIsaPkg::JR,
			mipsIsaPkg::JALR};
		bundle.jr = operation inside {mipsIsaPkg::JR, mipsIsaPkg::JALR};
		// lui goes through the shifter
		bundle.shift = operation inside {mipsIsaPkg::SLL, mipsIsaPkg::SRL, mipsIsaPkg::SRA,
			mipsIsaPkg::SLLV, mipsIsaPkg::SRLV, mipsIsaPkg::SRAV, mipsIsaPkg::LUI};
		bundle.link = operation inside {mipsIsaPkg::JAL, mipsIsaPkg::JALR,
			mipsIsaPkg::BLTZAL, mipsIsaPkg::BGEZAL};
	end

	// logical immediates are zero extended
	assign zeroExt = operation inside {mipsIsaPkg::ANDI, mipsIsaPkg::ORI, mipsIsaPkg::XORI};

	assign ctl.operation = operation;
	assign ctl.ctl = bundle;
	assign ctl.extImm = zeroExt ? {16'h0000, imm} : {{16{imm[15]}}, imm};
	assign ctl.exceptionRi = (operation == mipsIsaPkg::RESERVED);

endmodule

`default_nettype wire

/* source/mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [5:0] op_t;
	typedef logic [5:0] func_t;
	typedef logic [15:0] imm_t;
	typedef logic [25:0] jIndex_t;

	// primary opcodes
	localparam op_t OP_RTYPE = 6'h00;
	localparam op_t OP_REGIMM = 6'h01;
	localparam op_t OP_J = 6'h02;
	localparam op_t OP_JAL = 6'h03;
	localparam op_t OP_BEQ = 6'h04;
	localparam op_t OP_BNE = 6'h05;
	localparam op_t OP_BLEZ = 6'h06;
	localparam op_t OP_BGTZ = 6'h07;
	localparam op_t OP_ADDI = 6'h08;
	localparam op_t OP_ADDIU = 6'h09;
	localparam op_t OP_SLTI = 6'h0a;
	localparam op_t OP_SLTIU = 6'h0b;
	localparam op_t OP_ANDI = 6'h0c;
	localparam op_t OP_ORI = 6'h0d;
	localparam op_t OP_XORI = 6'h0e;
	localparam op_t OP_LUI = 6'h0f;
	localparam op_t OP_LB = 6'h20;
	localparam op_t OP_LH = 6'h21;
	localparam op_t OP_LW = 6'h23;
	localparam op_t OP_LBU = 6'h24;
	localparam op_t OP_LHU = 6'h25;
	localparam op_t OP_SB = 6'h28;
	localparam op_t OP_SH = 6'h29;
	localparam op_t OP_SW = 6'h2b;

	// funct field of R-type
	localparam func_t F_SLL = 6'h00;
	localparam func_t F_SRL = 6'h02;
	localparam func_t F_SRA = 6'h03;
	localparam func_t F_SLLV = 6'h04;
	localparam func_t F_SRLV = 6'h06;
	localparam func_t F_SRAV = 6'h07;
	localparam func_t F_JR = 6'h08;
	localparam func_t F_JALR = 6'h09;
	localparam func_t F_MFHI = 6'h10;
	localparam func_t F_MFLO = 6'h12;
	localparam func_t F_ADD = 6'h20;
	localparam func_t F_ADDU = 6'h21;
	localparam func_t F_SUB = 6'h22;
	localparam func_t F_SUBU = 6'h23;
	localparam func_t F_AND = 6'h24;
	localparam func_t F_OR = 6'h25;
	localparam func_t F_XOR = 6'h26;
	localparam func_t F_NOR = 6'h27;
	localparam func_t F_SLT = 6'h2a;
	localparam func_t F_SLTU = 6'h2b;

	// REGIMM selects the branch through the rt field
	localparam regAddr_t RT_BLTZ = 5'h00;
	localparam regAddr_t RT_BGEZ = 5'h01;
	localparam regAddr_t RT_BLTZAL = 5'h10;
	localparam regAddr_t RT_BGEZAL = 5'h11;

	// SLL first so an all-zero word decodes as the nop
	typedef enum logic [5:0] {
		SLL, SRL, SRA, SLLV, SRLV, SRAV,
		ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
		JR, JALR, MFHI, MFLO,
		ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
		LB, LBU, LH, LHU, LW, SB, SH, SW,
		BEQ, BNE, BLEZ, BGTZ, BLTZ, BGEZ, BLTZAL, BGEZAL,
		J, JAL,
		RESERVED
	} operation_t;

endpackage

`default_nettype wire

/* source/pipeReg.sv */
`default_nettype none
`timescale 1ns/100ps

module pipeReg #(
	parameter type payload_t = logic [31:0]
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic stall,
	input wire logic flush,
	input wire logic validIn,
	input wire payload_t dataIn,
	output logic validOut,
	output payload_t dataOut
);

	// flush wins over stall
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validOut <= 1'b0;
			dataOut <= '0;
		end else if (flush) begin
			validOut <= 1'b0;
			dataOut <= '0;
		end else if (!stall) begin
			validOut <= validIn;
			dataOut <= dataIn;
		end
	end

endmodule

`default_nettype wire

/* source/pipelinePkg.sv */
`default_nettype none

package pipelinePkg;

	typedef enum logic {RT, RD} regDst_t;
	typedef enum logic {REG, IMM} aluSrc_t;

	// operand source in decode
	typedef enum logic {FWD_NONE, FWD_MEM} forward_t;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		regDst_t regDst;
		aluSrc_t aluSrc;
		logic branch;
		logic jump;
		logic jr;
		logic shift;
		logic link;
	} ctl_t;

	typedef struct packed {
		mipsIsaPkg::word_t instr;
		mipsIsaPkg::word_t pcPlus4;
	} fetchData_t;

	typedef struct packed {
		mipsIsaPkg::operation_t operation;
		ctl_t ctl;
		mipsIsaPkg::regAddr_t rs;
		mipsIsaPkg::regAddr_t rt;
		mipsIsaPkg::regAddr_t rd;
		mipsIsaPkg::regAddr_t shamt;
		mipsIsaPkg::word_t extImm;
		mipsIsaPkg::word_t srcA;
		mipsIsaPkg::word_t srcB;
		mipsIsaPkg::word_t pcPlus4;
		logic exceptionRi;
	} decodeData_t;

endpackage

`default_nettype wire

/* source/regFile.sv */
`default_nettype none
`timescale 1ns/100ps

module regFile (
	input wire logic clk,
	input wire logic rstN,
	input wire logic wbWrite,
	input wire mipsIsaPkg::regAddr_t wbReg,
	input wire mipsIsaPkg::word_t wbData,
	regReadIntf.file rd
);

	mipsIsaPkg::word_t regs [32];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite && wbReg != '0) begin
			regs[wbReg] <= wbData;
		end
	end

	// $0 reads zero, same-cycle write bypasses the array
	function automatic mipsIsaPkg::word_t readReg(mipsIsaPkg::regAddr_t ra);
		if (ra == '0)
			return '0;
		if (wbWrite && ra == wbReg)
			return wbData;
		return regs[ra];
	endfunction

	always_comb begin
		rd.rd1 = readReg(rd.ra1);
		rd.rd2 = readReg(rd.ra2);
	end

endmodule

`default_nettype wire

/* source/stageIntf.sv */
`default_nettype none
`timescale 1ns/100ps

// register file read ports
interface regReadIntf;
	mipsIsaPkg::regAddr_t ra1;
	mipsIsaPkg::regAddr_t ra2;
	mipsIsaPkg::word_t rd1;
	mipsIsaPkg::word_t rd2;

	modport reader (output ra1, ra2, input rd1, rd2);
	modport file (input ra1, ra2, output rd1, rd2);
endinterface

// instruction out, decoded fields back
interface decodeCtlIntf;
	mipsIsaPkg::word_t instr;
	mipsIsaPkg::operation_t operation;
	pipelinePkg::ctl_t ctl;
	mipsIsaPkg::word_t extImm;
	logic exceptionRi;

	modport stage (output instr, input operation, ctl, extImm, exceptionRi);
	modport decoder (input instr, output operation, ctl, extImm, exceptionRi);
endinterface

// next-pc candidates resolved in decode
interface pcSelectIntf;
	mipsIsaPkg::word_t pcBranch;
	mipsIsaPkg::word_t pcJump;
	mipsIsaPkg::word_t pcJr;
	logic branchTaken;
	logic jump;
	logic jr;

	modport source (output pcBranch, pcJump, pcJr, branchTaken, jump, jr);
	modport sink (input pcBranch, pcJump, pcJr, branchTaken, jump, jr);
endinterface

`default_nettype wire

/* tb.f */
source/mipsIsaPkg.sv
source/pipelinePkg.sv
source/stageIntf.sv
source/pipeReg.sv
source/instrDecoder.sv
source/regFile.sv
source/decodeStage.sv
source/decodeTop.sv
tests/decodeTb.sv

/* tests/decodeTb.sv */
`default_nettype none
`timescale 1ns/100ps

module decodeTb;

	localparam mipsIsaPkg::word_t RESET_PC = 32'hbfc0_0000;
	localparam int NUM_CYCLES = 3000;
	localparam int DRAIN_TIMEOUT = 20;

	logic clk;
	logic rstN;
	logic stallD;
	logic flushD;
	logic fetchValid;
	mipsIsaPkg::word_t instr;
	mipsIsaPkg::word_t pcPlus4;
	logic regWriteM;
	mipsIsaPkg::regAddr_t writeRegM;
	mipsIsaPkg::word_t aluOutM;
	logic wbWrite;
	mipsIsaPkg::regAddr_t wbReg;
	mipsIsaPkg::word_t wbData;
	mipsIsaPkg::word_t pcBranch;
	mipsIsaPkg::word_t pcJump;
	mipsIsaPkg::word_t pcJr;
	logic branchTaken;
	logic jump;
	logic jr;
	logic execValid;
	mipsIsaPkg::operation_t execOperation;
	pipelinePkg::ctl_t execCtl;
	mipsIsaPkg::regAddr_t execRs;
	mipsIsaPkg::regAddr_t execRt;
	mipsIsaPkg::regAddr_t execRd;
	mipsIsaPkg::regAddr_t execShamt;
	mipsIsaPkg::word_t execExtImm;
	mipsIsaPkg::word_t execSrcA;
	mipsIsaPkg::word_t execSrcB;
	mipsIsaPkg::word_t execPcPlus4;
	logic execExceptionRi;

	integer seed;
	int errors;
	int checks;
	logic draining;

	// model of IF/ID, ID/EX and the register array
	logic ifValidM;
	mipsIsaPkg::word_t ifInstrM;
	mipsIsaPkg::word_t ifPcM;
	logic idExValidM;
	pipelinePkg::decodeData_t idExM;
	mipsIsaPkg::word_t regModel [32];

	// supported encodings for the stimulus
	logic [5:0] validOps [22] = '{6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08, 6'h09,
		6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h20, 6'h21, 6'h23, 6'h24, 6'h25,
		6'h28, 6'h29, 6'h2b};
	logic [5:0] rFuncts [20] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09,
		6'h10, 6'h12, 6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
	logic [4:0] regimmRts [4] = '{5'h00, 5'h01, 5'h10, 5'h11};

	decodeTop #(
		.RESET_PC(RESET_PC)
	) DUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// MIPS encoding table, written from the ISA manual
	function automatic mipsIsaPkg::operation_t lookupOperation(mipsIsaPkg::word_t w);
		case (w[31:26])
			6'h00: begin
				case (w[5:0])
					6'h00: return mipsIsaPkg::SLL;
					6'h02: return mipsIsaPkg::SRL;
					6'h03: return mipsIsaPkg::SRA;
					6'h04: return mipsIsaPkg::SLLV;
					6'h06: return mipsIsaPkg::SRLV;
					6'h07: return mipsIsaPkg::SRAV;
					6'h08: return mipsIsaPkg::JR;
					6'h09: return mipsIsaPkg::JALR;
					6'h10: return mipsIsaPkg::MFHI;
					6'h12: return mipsIsaPkg::MFLO;
					6'h20: return mipsIsaPkg::ADD;
					6'h21: return mipsIsaPkg::ADDU;
					6'h22: return mipsIsaPkg::SUB;
					6'h23: return mipsIsaPkg::SUBU;
					6'h24: return mipsIsaPkg::AND;
					6'h25: return mipsIsaPkg::OR;
					6'h26: return mipsIsaPkg::XOR;
					6'h27: return mipsIsaPkg::NOR;
					6'h2a: return mipsIsaPkg::SLT;
					6'h2b: return mipsIsaPkg::SLTU;
					default: return mipsIsaPkg::RESERVED;
				endcase
			end
			6'h01: begin
				case (w[20:16])
					5'h00: return mipsIsaPkg::BLTZ;
					5'h01: return mipsIsaPkg::BGEZ;
					5'h10: return mipsIsaPkg::BLTZAL;
					5'h11: return mipsIsaPkg::BGEZAL;
					default: return mipsIsaPkg::RESERVED;
				endcase
			end
			6'h02: return mipsIsaPkg::J;
			6'h03: return mipsIsaPkg::JAL;
			6'h04: return mipsIsaPkg::BEQ;
			6'h05: return mipsIsaPkg::BNE;
			6'h06: return mipsIsaPkg::BLEZ;
			6'h07: return mipsIsaPkg::BGTZ;
			6'h08: return mipsIsaPkg::ADDI;
			6'h09: return mipsIsaPkg::ADDIU;
			6'h0a: return mipsIsaPkg::SLTI;
			6'h0b: return mipsIsaPkg::SLTIU;
			6'h0c: return mipsIsaPkg::ANDI;
			6'h0d: return mipsIsaPkg::ORI;
			6'h0e: return mipsIsaPkg::XORI;
			6'h0f: return mipsIsaPkg::LUI;
			6'h20: return mipsIsaPkg::LB;
			6'h21: return mipsIsaPkg::LH;
			6'h23: return mipsIsaPkg::LW;
			6'h24: return mipsIsaPkg::LBU;
			6'h25: return mipsIsaPkg::LHU;
			6'h28: return mipsIsaPkg::SB;
			6'h29: return mipsIsaPkg::SH;
			6'h2b: return mipsIsaPkg::SW;
			default: return mipsIsaPkg::RESERVED;
		endcase
	endfunction

	function automatic pipelinePkg::ctl_t controlBundle(mipsIsaPkg::operation_t opn,
		logic [5:0] opcode);
		pipelinePkg::ctl_t c;
		c = '0;
		c.memRead = opn inside {mipsIsaPkg::LB, mipsIsaPkg::LBU, mipsIsaPkg::LH,
			mipsIsaPkg::LHU, mipsIsaPkg::LW};
		c.memWrite = opn inside {mipsIsaPkg::SB, mipsIsaPkg::SH, mipsIsaPkg::SW};
		c.branch = opn inside {mipsIsaPkg::BEQ, mipsIsaPkg::BNE, mipsIsaPkg::BLEZ,
			mipsIsaPkg::BGTZ, mipsIsaPkg::BLTZ, mipsIsaPkg::BGEZ, mipsIsaPkg::BLTZAL,
			mipsIsaPkg::BGEZAL};
		c.jr = opn inside {mipsIsaPkg::JR, mipsIsaPkg::JALR};
		c.jump = c.jr || (opn inside {mipsIsaPkg::J, mipsIsaPkg::JAL});
		c.link = opn inside {mipsIsaPkg::JAL, mipsIsaPkg::JALR, mipsIsaPkg::BLTZAL,
			mipsIsaPkg::BGEZAL};
		c.shift = opn inside {mipsIsaPkg::SLL, mipsIsaPkg::SRL, mipsIsaPkg::SRA,
			mipsIsaPkg::SLLV, mipsIsaPkg::SRLV, mipsIsaPkg::SRAV, mipsIsaPkg::LUI};
		// linking ops write r31 or rd, everything else that is not store or control flow
		c.regWrite = c.link || (opn != mipsIsaPkg::RESERVED && !c.memWrite && !c.branch &&
			!c.jump);
		c.regDst = (opcode == 6'h00) ? pipelinePkg::RD : pipelinePkg::RT;
		c.aluSrc = (opcode == 6'h00) ? pipelinePkg::REG : pipelinePkg::IMM;
		return c;
	endfunction

	function automatic mipsIsaPkg::word_t extendImm(mipsIsaPkg::word_t w);
		if (w[31:26] inside {6'h0c, 6'h0d, 6'h0e})
			return {16'h0000, w[15:0]};
		return {{16{w[15]}}, w[15:0]};
	endfunction

	// MEM result first, then the write port, then the array
	function automatic mipsIsaPkg::word_t operandValue(mipsIsaPkg::regAddr_t r);
		if (r == 5'd0)
			return '0;
		if (regWriteM && writeRegM == r)
			return aluOutM;
		if (wbWrite && wbReg == r)
			return wbData;
		return regModel[r];
	endfunction

	function automatic pipelinePkg::decodeData_t expectedDecode();
		pipelinePkg::decodeData_t d;
		d = '0;
		d.operation = lookupOperation(ifInstrM);
		if (ifValidM)
			d.ctl = controlBundle(d.operation, ifInstrM[31:26]);
		d.rs = ifInstrM[25:21];
		d.rt = ifInstrM[20:16];
		d.rd = ifInstrM[15:11];
		d.shamt = ifInstrM[10:6];
		d.extImm = extendImm(ifInstrM);
		d.srcA = operandValue(d.rs);
		d.srcB = operandValue(d.rt);
		d.pcPlus4 = ifPcM;
		d.exceptionRi = ifValidM && (d.operation == mipsIsaPkg::RESERVED);
		return d;
	endfunction

	function automatic logic branchResolves(pipelinePkg::decodeData_t d);
		case (d.operation)
			mipsIsaPkg::BEQ: return d.srcA == d.srcB;
			mipsIsaPkg::BNE: return d.srcA != d.srcB;
			mipsIsaPkg::BGEZ, mipsIsaPkg::BGEZAL: return $signed(d.srcA) >= 0;
			mipsIsaPkg::BLTZ, mipsIsaPkg::BLTZAL: return $signed(d.srcA) < 0;
			mipsIsaPkg::BGTZ: return $signed(d.srcA) > 0;
			mipsIsaPkg::BLEZ: return $signed(d.srcA) <= 0;
			default: return 1'b0;
		endcase
	endfunction

	task automatic compare(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkIdle();
		compare("execValid after reset", execValid, 1'b0);
		compare("branchTaken after reset", branchTaken, 1'b0);
		compare("jump after reset", jump, 1'b0);
		compare("jr after reset", jr, 1'b0);
		compare("execCtl.regWrite after reset", execCtl.regWrite, 1'b0);
		compare("execCtl.memRead after reset", execCtl.memRead, 1'b0);
		compare("execCtl.memWrite after reset", execCtl.memWrite, 1'b0);
	endtask

	// sampled at the falling edge, away from both clock and input changes
	task automatic checkOutputs();
		pipelinePkg::decodeData_t d;
		d = expectedDecode();
		compare("branchTaken", branchTaken, d.ctl.branch && branchResolves(d));
		compare("jump", jump, d.ctl.jump);
		compare("jr", jr, d.ctl.jr);
		if (d.ctl.branch)
			compare("pcBranch", pcBranch, ifPcM + (d.extImm << 2));
		if (d.ctl.jump && !d.ctl.jr)
			compare("pcJump", pcJump, {ifPcM[31:28], ifInstrM[25:0], 2'b00});
		if (d.ctl.jr)
			compare("pcJr", pcJr, d.srcA);
		compare("execValid", execValid, idExValidM);
		compare("execCtl", execCtl, idExM.ctl);
		compare("execExceptionRi", execExceptionRi, idExM.exceptionRi);
		compare("execPcPlus4", execPcPlus4, idExM.pcPlus4);
		if (idExValidM) begin
			compare("execOperation", execOperation, idExM.operation);
			compare("execRs", execRs, idExM.rs);
			compare("execRt", execRt, idExM.rt);
			compare("execRd", execRd, idExM.rd);
			compare("execShamt", execShamt, idExM.shamt);
			compare("execExtImm", execExtImm, idExM.extImm);
			compare("execSrcA", execSrcA, idExM.srcA);
			compare("execSrcB", execSrcB, idExM.srcB);
		end
	endtask

	// one clock edge of the stage, from the inputs the DUT sees at it
	task automatic advanceModel();
		pipelinePkg::decodeData_t d;
		d = expectedDecode();
		if (ifValidM && !stallD) begin
			idExValidM = 1'b1;
			idExM = d;
		end else begin
			idExValidM = 1'b0;
			idExM = '0;
			// a bubble carries the reset pc
			idExM.pcPlus4 = RESET_PC;
		end
		if (flushD) begin
			ifValidM = 1'b0;
			ifInstrM = '0;
			ifPcM = '0;
		end else if (!stallD) begin
			ifValidM = fetchValid;
			ifInstrM = instr;
			ifPcM = pcPlus4;
		end
		if (wbWrite && wbReg != 5'd0)
			regModel[wbReg] = wbData;
	endtask

	function automatic logic chance(int unsigned pct);
		int unsigned r;
		r = $random(seed);
		return (r % 100) < pct;
	endfunction

	function automatic int unsigned randomIndex(int unsigned n);
		int unsigned r;
		r = $random(seed);
		return r % n;
	endfunction

	function automatic mipsIsaPkg::regAddr_t randomReg();
		mipsIsaPkg::word_t r;
		r = $random(seed);
		return r[4:0];
	endfunction

	// small pool so that equal and zero operands show up often
	function automatic mipsIsaPkg::word_t randomValue();
		mipsIsaPkg::word_t r;
		r = $random(seed);
		case (r[1:0])
			2'd0: return '0;
			2'd1: return {30'h0, r[3:2]};
			2'd2: return {28'hfff_ffff, r[5:2]};
			default: begin
				r = $random(seed);
				return r;
			end
		endcase
	endfunction

	function automatic mipsIsaPkg::word_t randomInstr();
		mipsIsaPkg::word_t w;
		int unsigned pick;
		int tries;
		w = $random(seed);
		pick = randomIndex(20);
		tries = 0;
		if (pick < 5) begin
			w[31:26] = 6'h00;
			w[5:0] = rFuncts[randomIndex(20)];
		end else if (pick < 7) begin
			w[31:26] = 6'h01;
			w[20:16] = regimmRts[randomIndex(4)];
		end else if (pick < 17) begin
			w[31:26] = validOps[randomIndex(22)];
		end else begin
			// unlisted encodings, one draw in three an unknown funct
			if (pick == 19)
				w[31:26] = 6'h00;
			while (lookupOperation(w) != mipsIsaPkg::RESERVED && tries < 64) begin
				w = $random(seed);
				if (pick == 19)
					w[31:26] = 6'h00;
				tries++;
			end
			if (lookupOperation(w) != mipsIsaPkg::RESERVED)
				w[31:26] = 6'h3f;
		end
		return w;
	endfunction

	// forward and write-back targets lean on the instruction now in IF/ID
	task automatic driveInputs();
		fetchValid <= !draining && chance(90);
		instr <= randomInstr();
		pcPlus4 <= randomValue() & 32'hffff_fffc;
		stallD <= !draining && chance(10);
		flushD <= !draining && chance(7);
		regWriteM <= chance(30);
		writeRegM <= chance(50) ? ifInstrM[25:21] : randomReg();
		aluOutM <= randomValue();
		wbWrite <= chance(40);
		wbReg <= chance(30) ? ifInstrM[25:21] : (chance(30) ? ifInstrM[20:16] : randomReg());
		wbData <= randomValue();
	endtask

	task automatic stepCycle();
		@(posedge clk);
		advanceModel();
		driveInputs();
		@(negedge clk);
		checkOutputs();
	endtask

	initial begin
		int waited;
		seed = 32'hd3ec_eb8f;
		errors = 0;
		checks = 0;
		draining = 1'b0;
		rstN = 1'b0;
		stallD = 1'b0;
		flushD = 1'b0;
		fetchValid = 1'b0;
		instr = '0;
		pcPlus4 = '0;
		regWriteM = 1'b0;
		writeRegM = '0;
		aluOutM = '0;
		wbWrite = 1'b0;
		wbReg = '0;
		wbData = '0;
		ifValidM = 1'b0;
		ifInstrM = '0;
		ifPcM = '0;
		idExValidM = 1'b0;
		idExM = '0;
		for (int i = 0; i < 32; i++)
			regModel[i] = '0;

		repeat (4) @(posedge clk);
		@(negedge clk);
		checkIdle();
		@(posedge clk);
		rstN <= 1'b1;

		for (int n = 0; n < NUM_CYCLES; n++)
			stepCycle();

		// stop issuing, both registers should empty
		draining = 1'b1;
		stepCycle();
		stepCycle();
		waited = 0;
		while (execValid !== 1'b0 && waited < DRAIN_TIMEOUT) begin
			stepCycle();
			waited++;
		end
		if (execValid !== 1'b0) begin
			errors++;
			$display("timeout: execValid still high %0d cycles after issue stopped",
				DRAIN_TIMEOUT);
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
